//--- tb.f
design/board_pkg.sv
design/input_debouncer.sv
design/uart_receiver.sv
design/uart_transmitter.sv
design/cmd_engine.sv
design/io_regs.sv
design/seg_scan.sv
design/board_top.sv
verif/board_asserts.sv
verif/tb_board_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_board_top
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP) -f tb.f
	@out="$$(./$(OBJ_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_board_top.sv
module tb_board_top;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 40;
    localparam int CPB           = board_pkg::CLKS_PER_BIT;
    localparam int SETTLE_CYCLES = 2 * (2 + board_pkg::DEBOUNCE_CYCLES) + 4;
    localparam int FRAME_GAP     = 2 * CPB;
    localparam int REPLY_WAIT    = 40 * CPB;
    localparam int N_LED         = 8;
    localparam int N_SW          = 6;
    localparam int N_BTN         = 8;
    localparam int N_SEG         = 4;
    localparam int N_BAD         = 4;
    localparam int N_FRAMES      = 2 * N_LED + N_SW + 3 * N_BTN + 4 * N_SEG + 3 * N_BAD;
    localparam longint WATCHDOG_NS = longint'(N_FRAMES) * 10 * 10 * CPB * CLK_PERIOD * 2;

    logic            clk;
    logic            rst_n;
    logic            uart_rx;
    board_pkg::sw_t  sw;
    board_pkg::btn_t btn;
    logic [15:0]     led;
    logic [7:0]      seg;
    logic [7:0]      an;
    logic            uart_tx;

    integer      seed;
    int          errors;
    logic [15:0] led_m;     // expected register contents
    logic [31:0] segv_m;
    logic [7:0]  sege_m;
    logic [15:0] sw_m;
    logic [4:0]  btn_m;
    logic [4:0]  evt_m;

    board_top i_board_top (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .uart_rx ( uart_rx ),
        .sw      ( sw      ),
        .btn     ( btn     ),
        .led     ( led     ),
        .seg     ( seg     ),
        .an      ( an      ),
        .uart_tx ( uart_tx )
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [7:0] rand_non_opcode();
        logic [31:0] r;
        r = next_rand();
        while (r[7:0] == board_pkg::OP_WRITE || r[7:0] == board_pkg::OP_READ) r = next_rand();
        return r[7:0];
    endfunction

    function automatic logic [7:0] rand_unmapped_addr();
        logic [31:0] r;
        r = next_rand();
        while (r[7:0] == board_pkg::ADDR_LED || r[7:0] == board_pkg::ADDR_SEG_VALUE ||
               r[7:0] == board_pkg::ADDR_SEG_ENABLE || r[7:0] == board_pkg::ADDR_SWITCHES ||
               r[7:0] == board_pkg::ADDR_BUTTONS) r = next_rand();
        return r[7:0];
    endfunction

    function automatic logic [31:0] model_read(input logic [7:0] addr);
        case (addr)
            board_pkg::ADDR_LED:        return {16'h0, led_m};
            board_pkg::ADDR_SEG_VALUE:  return segv_m;
            board_pkg::ADDR_SEG_ENABLE: return {24'h0, sege_m};
            board_pkg::ADDR_SWITCHES:   return {16'h0, sw_m};
            board_pkg::ADDR_BUTTONS:    return {19'h0, evt_m, 3'h0, btn_m};
            default:                    return 32'h0;
        endcase
    endfunction

    function automatic void apply_write(input logic [7:0] addr, input logic [31:0] data);
        case (addr)
            board_pkg::ADDR_LED:        led_m  = data[15:0];
            board_pkg::ADDR_SEG_VALUE:  segv_m = data;
            board_pkg::ADDR_SEG_ENABLE: sege_m = data[7:0];
            board_pkg::ADDR_BUTTONS:    evt_m  = evt_m & ~data[12:8]; // write one to clear
            default:                    ;
        endcase
    endfunction

    // a..g lit pattern per hex digit, returned active low with dp dark
    function automatic logic [7:0] seg_pattern(input logic [3:0] digit);
        logic [6:0] lit;
        case (digit)
            4'h0: lit = 7'b1111110;
            4'h1: lit = 7'b0110000;
            4'h2: lit = 7'b1101101;
            4'h3: lit = 7'b1111001;
            4'h4: lit = 7'b0110011;
            4'h5: lit = 7'b1011011;
            4'h6: lit = 7'b1011111;
            4'h7: lit = 7'b1110000;
            4'h8: lit = 7'b1111111;
            4'h9: lit = 7'b1111011;
            4'hA: lit = 7'b1110111;
            4'hB: lit = 7'b0011111;
            4'hC: lit = 7'b1001110;
            4'hD: lit = 7'b0111101;
            4'hE: lit = 7'b1001111;
            default: lit = 7'b1000111;
        endcase
        return {~lit, 1'b1};
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic send_byte(input logic [7:0] b);
        int i;
        uart_rx = 1'b0; // start bit
        wait_cycles(CPB);
        for (i = 0; i < 8; i++) begin
            uart_rx = b[i];
            wait_cycles(CPB);
        end
        uart_rx = 1'b1;
        wait_cycles(CPB);
    endtask

    task automatic recv_byte(output logic [7:0] b, output bit ok);
        int waited;
        int i;
        ok = 1'b0;
        b = '0;
        waited = 0;
        while (uart_tx !== 1'b0 && waited < REPLY_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (uart_tx !== 1'b0) begin
            $display("no reply byte arrived on uart_tx by %0t ns", $time);
            errors++;
            return;
        end
        wait_cycles(CPB / 2); // middle of the start bit
        for (i = 0; i < 8; i++) begin
            wait_cycles(CPB);
            b[i] = uart_tx;
        end
        wait_cycles(CPB);
        if (uart_tx !== 1'b1) begin
            $display("reply byte at %0t ns has a low stop bit", $time);
            errors++;
            return;
        end
        ok = 1'b1;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        int n;
        send_byte(board_pkg::OP_WRITE);
        send_byte(addr);
        for (n = 3; n >= 0; n--) send_byte(data[n*8 +: 8]);
        wait_cycles(FRAME_GAP);
        apply_write(addr, data);
        if (led !== led_m) begin
            $display("[FAIL] %0t ns: led is 0x%04h, expected 0x%04h", $time, led, led_m);
            errors++;
        end
    endtask

    task automatic check_read(input logic [7:0] addr);
        logic [31:0] got;
        logic [31:0] exp;
        logic [7:0]  b;
        bit          ok;
        int          n;
        exp = model_read(addr);
        got = '0;
        ok  = 1'b1;
        send_byte(board_pkg::OP_READ);
        send_byte(addr);
        for (n = 0; n < 4; n++) begin
            if (ok) begin
                recv_byte(b, ok);
                got = {got[23:0], b}; // msb first
            end
        end
        if (ok && got !== exp) begin
            $display("[FAIL] %0t ns: read of 0x%02h returned 0x%08h, expected 0x%08h",
                     $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic set_buttons(input logic [4:0] level);
        btn = level;
        wait_cycles(SETTLE_CYCLES);
        evt_m = evt_m | (level & ~btn_m); // rising edges latch an event
        btn_m = level;
    endtask

    task automatic send_bad_frame();
        int  c;
        bit  heard;
        heard = 1'b0;
        send_byte(rand_non_opcode());
        send_byte(rand_non_opcode());
        for (c = 0; c < 20 * CPB; c++) begin
            @(negedge clk);
            if (uart_tx !== 1'b1 && !heard) begin
                $display("uart_tx sent a reply to an unknown opcode at %0t ns", $time);
                errors++;
                heard = 1'b1;
            end
        end
    endtask

    task automatic watch_scan();
        logic [7:0] low;
        logic [7:0] seen;
        int         c;
        int         i;
        seen = '0;
        for (c = 0; c < 64 * board_pkg::SCAN_CYCLES; c++) begin
            @(negedge clk);
            low  = ~an;
            seen = seen | low;
            if ($countones(low) > 1) begin
                $display("[FAIL] %0t ns: several anodes low at once, an=%b", $time, an);
                errors++;
            end
            for (i = 0; i < 8; i++) begin
                if (low[i] && !sege_m[i]) begin
                    $display("[FAIL] %0t ns: disabled digit %0d lit", $time, i);
                    errors++;
                end else if (low[i] && seg !== seg_pattern(segv_m[i*4 +: 4])) begin
                    $display("[FAIL] %0t ns: digit %0d shows seg=%b, expected %b",
                             $time, i, seg, seg_pattern(segv_m[i*4 +: 4]));
                    errors++;
                end
            end
        end
        if (seen !== sege_m) begin
            $display("[FAIL] %0t ns: digits lit %b, enabled %b", $time, seen, sege_m);
            errors++;
        end
    endtask

    initial begin
        logic [31:0] r;
        int          k;
        rst_n   = 1'b0;
        uart_rx = 1'b1;
        sw      = '0;
        btn     = '0;
        seed    = 65459;
        errors  = 0;
        led_m   = '0;
        segv_m  = '0;
        sege_m  = '0;
        sw_m    = '0;
        btn_m   = '0;
        evt_m   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_cycles(2);
        if (uart_tx !== 1'b1 || led !== 16'h0 || an !== 8'hFF) begin
            $display("[FAIL] %0t ns: after reset uart_tx=%b led=0x%04h an=%b",
                     $time, uart_tx, led, an);
            errors++;
        end

        for (k = 0; k < N_LED; k++) begin
            write_reg(board_pkg::ADDR_LED, next_rand());
            check_read(board_pkg::ADDR_LED);
        end

        for (k = 0; k < N_SW; k++) begin
            r  = next_rand();
            sw = r[15:0];
            wait_cycles(SETTLE_CYCLES);
            sw_m = r[15:0];
            check_read(board_pkg::ADDR_SWITCHES);
        end

        for (k = 0; k < N_BTN; k++) begin
            r = next_rand();
            set_buttons(r[4:0]);
            check_read(board_pkg::ADDR_BUTTONS);
            write_reg(board_pkg::ADDR_BUTTONS, next_rand()); // random clear mask in 12:8
            check_read(board_pkg::ADDR_BUTTONS);
        end

        for (k = 0; k < N_SEG; k++) begin
            write_reg(board_pkg::ADDR_SEG_VALUE, next_rand());
            write_reg(board_pkg::ADDR_SEG_ENABLE, next_rand());
            check_read(board_pkg::ADDR_SEG_VALUE);
            check_read(board_pkg::ADDR_SEG_ENABLE);
            watch_scan();
        end

        for (k = 0; k < N_BAD; k++) begin
            send_bad_frame();
            if (led !== led_m) begin
                $display("[FAIL] %0t ns: unknown frame changed led to 0x%04h", $time, led);
                errors++;
            end
            check_read(rand_unmapped_addr());
            check_read(board_pkg::ADDR_LED);
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired, the run took longer than %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verif/board_asserts.sv
module board_asserts (
    input logic                clk,
    input logic                rst_n,
    input board_pkg::bus_req_t bus_req,
    input logic                bus_req_valid,
    input logic                bus_ack,
    input logic                tx_req,
    input logic                tx_ack
);

    timeunit 1ns;
    timeprecision 1ps;

    // request stays up and unchanged until the register block answers
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_req_valid && !bus_ack) |=> (bus_req_valid && $stable(bus_req)))
        else $error("bus request dropped or changed before bus_ack rose");

    a_req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_req_valid) |-> !$past(bus_ack))
        else $error("bus_req_valid rose while bus_ack was still high");

    a_tx_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(tx_req) |-> !$past(tx_ack))
        else $error("tx_req rose while tx_ack was still high");

endmodule

bind cmd_engine board_asserts u_board_asserts (
    .clk           ( clk           ),
    .rst_n         ( rst_n         ),
    .bus_req       ( bus_req       ),
    .bus_req_valid ( bus_req_valid ),
    .bus_ack       ( bus_ack       ),
    .tx_req        ( tx_req        ),
    .tx_ack        ( tx_ack        )
);

//--- design/board_top.sv
module board_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            uart_rx,
    input  board_pkg::sw_t  sw,
    input  board_pkg::btn_t btn,
    output logic [15:0]     led,
    output logic [7:0]      seg,
    output logic [7:0]      an,
    output logic            uart_tx
);

    board_pkg::sw_t      sw_db;
    board_pkg::btn_t     btn_db;
    logic [7:0]          rx_data;
    logic                rx_valid;
    board_pkg::bus_req_t bus_req;
    logic                bus_req_valid;
    logic                bus_ack;
    board_pkg::bus_rsp_t bus_rsp;
    logic [7:0]          tx_data;
    logic                tx_req;
    logic                tx_ack;
    logic [31:0]         seg_value;
    logic [7:0]          seg_enable;

    input_debouncer #(.payload_t (board_pkg::sw_t)) u_sw_debouncer (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .raw   ( sw    ),
        .clean ( sw_db )
    );

    input_debouncer #(.payload_t (board_pkg::btn_t)) u_btn_debouncer (
        .clk   ( clk    ),
        .rst_n ( rst_n  ),
        .raw   ( btn    ),
        .clean ( btn_db )
    );

    uart_receiver u_uart_receiver (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .rx       ( uart_rx  ),
        .rx_data  ( rx_data  ),
        .rx_valid ( rx_valid )
    );

    uart_transmitter u_uart_transmitter (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .tx_data ( tx_data ),
        .tx_req  ( tx_req  ),
        .tx_ack  ( tx_ack  ),
        .tx      ( uart_tx )
    );

    // stands in for the processor as bus master
    cmd_engine u_cmd_engine (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .rx_data       ( rx_data       ),
        .rx_valid      ( rx_valid      ),
        .bus_req       ( bus_req       ),
        .bus_req_valid ( bus_req_valid ),
        .bus_ack       ( bus_ack       ),
        .bus_rsp       ( bus_rsp       ),
        .tx_data       ( tx_data       ),
        .tx_req        ( tx_req        ),
        .tx_ack        ( tx_ack        )
    );

    io_regs u_io_regs (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .bus_req       ( bus_req       ),
        .bus_req_valid ( bus_req_valid ),
        .bus_ack       ( bus_ack       ),
        .bus_rsp       ( bus_rsp       ),
        .sw_db         ( sw_db         ),
        .btn_db        ( btn_db        ),
        .led           ( led           ),
        .seg_value     ( seg_value     ),
        .seg_enable    ( seg_enable    )
    );

    seg_scan u_seg_scan (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .seg_value  ( seg_value  ),
        .seg_enable ( seg_enable ),
        .seg        ( seg        ),
        .an         ( an         )
    );

endmodule

//--- design/seg_scan.sv
module seg_scan (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] seg_value,
    input  logic [7:0]  seg_enable,
    output logic [7:0]  seg,
    output logic [7:0]  an
);

    localparam int CNT_W = $clog2(board_pkg::SCAN_CYCLES + 1);

    logic [CNT_W-1:0] scan_cnt;
    logic [2:0]       digit_idx;
    logic [3:0]       nibble;

    // segments a..g, active high
    function automatic logic [6:0] hex_to_seg(input logic [3:0] h);
        case (h)
            4'h0: return 7'h7E;
            4'h1: return 7'h30;
            4'h2: return 7'h6D;
            4'h3: return 7'h79;
            4'h4: return 7'h33;
            4'h5: return 7'h5B;
            4'h6: return 7'h5F;
            4'h7: return 7'h70;
            4'h8: return 7'h7F;
            4'h9: return 7'h7B;
            4'hA: return 7'h77;
            4'hB: return 7'h1F;
            4'hC: return 7'h4E;
            4'hD: return 7'h3D;
            4'hE: return 7'h4F;
            default: return 7'h47;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt  <= '0;
            digit_idx <= '0;
        end else if (scan_cnt == CNT_W'(board_pkg::SCAN_CYCLES - 1)) begin
            scan_cnt  <= '0;
            digit_idx <= digit_idx + 1'b1; // wraps 7 -> 0
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign nibble = seg_value[digit_idx*4 +: 4];
    assign seg    = {~hex_to_seg(nibble), 1'b1}; // dp off
    assign an     = ~(seg_enable & (8'b1 << digit_idx));

endmodule

//--- design/io_regs.sv
module io_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  board_pkg::bus_req_t bus_req,
    input  logic                bus_req_valid,
    output logic                bus_ack,
    output board_pkg::bus_rsp_t bus_rsp,
    input  board_pkg::sw_t      sw_db,
    input  board_pkg::btn_t     btn_db,
    output logic [15:0]         led,
    output logic [31:0]         seg_value,
    output logic [7:0]          seg_enable
);

    logic        access;
    logic        wr_en;
    logic [31:0] rdata;
    logic [4:0]  btn_lvl;
    logic [4:0]  btn_prev;
    logic [4:0]  btn_evt;   // sticky press events
    logic [4:0]  press;
    logic [4:0]  evt_clr;

    assign access  = bus_req_valid && !bus_ack; // first cycle of a transfer
    assign wr_en   = access && bus_req.write;
    assign btn_lvl = btn_db;
    assign press   = btn_lvl & ~btn_prev;
    assign evt_clr = (wr_en && bus_req.addr == board_pkg::ADDR_BUTTONS) ?
                     bus_req.wdata[12:8] : 5'b0;

    always_comb begin
        case (bus_req.addr)
            board_pkg::ADDR_LED:        rdata = {16'b0, led};
            board_pkg::ADDR_SEG_VALUE:  rdata = seg_value;
            board_pkg::ADDR_SEG_ENABLE: rdata = {24'b0, seg_enable};
            board_pkg::ADDR_SWITCHES:   rdata = {16'b0, sw_db};
            board_pkg::ADDR_BUTTONS:    rdata = {19'b0, btn_evt, 3'b0, btn_lvl};
            default:                    rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_ack    <= 1'b0;
            led        <= '0;
            seg_value  <= '0;
            seg_enable <= '0;
            btn_prev   <= '0;
            btn_evt    <= '0;
        end else begin
            if (access) begin
                bus_ack <= 1'b1;
            end else if (!bus_req_valid) begin
                bus_ack <= 1'b0;
            end

            if (wr_en) begin
                case (bus_req.addr)
                    board_pkg::ADDR_LED:        led        <= bus_req.wdata[15:0];
                    board_pkg::ADDR_SEG_VALUE:  seg_value  <= bus_req.wdata;
                    board_pkg::ADDR_SEG_ENABLE: seg_enable <= bus_req.wdata[7:0];
                    default:                    ;
                endcase
            end

            btn_prev <= btn_lvl;
            btn_evt  <= (btn_evt & ~evt_clr) | press; // a new press wins over clear
        end
    end

    always_ff @(posedge clk) begin
        if (access) bus_rsp.rdata <= rdata;
    end

endmodule

//--- design/cmd_engine.sv
module cmd_engine (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [7:0]         rx_data,
    input  logic               rx_valid,
    output board_pkg::bus_req_t bus_req,
    output logic               bus_req_valid,
    input  logic               bus_ack,
    input  board_pkg::bus_rsp_t bus_rsp,
    output logic [7:0]         tx_data,
    output logic               tx_req,
    input  logic               tx_ack
);

    typedef enum logic [2:0] {
        C_OPCODE,
        C_ADDR,
        C_DATA,
        C_BUS,
        C_REPLY
    } state_t;

    state_t      state;
    logic [1:0]  byte_cnt;
    logic        is_write;
    logic [7:0]  addr_q;
    logic [31:0] wdata_q;
    logic [31:0] reply_q;

    always_comb begin
        bus_req.write = is_write;
        bus_req.addr  = addr_q;
        bus_req.wdata = wdata_q;
    end

    assign tx_data = reply_q[31:24]; // msb first

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= C_OPCODE;
            byte_cnt      <= '0;
            bus_req_valid <= 1'b0;
            tx_req        <= 1'b0;
        end else begin
            case (state)
                C_OPCODE: begin
                    if (rx_valid) begin
                        if (rx_data == board_pkg::OP_WRITE || rx_data == board_pkg::OP_READ) begin
                            state <= C_ADDR;
                        end
                    end
                end
                C_ADDR: begin
                    if (rx_valid) begin
                        byte_cnt <= '0;
                        state    <= is_write ? C_DATA : C_BUS;
                    end
                end
                C_DATA: begin
                    if (rx_valid) begin
                        if (byte_cnt == 2'd3) state <= C_BUS;
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                C_BUS: begin
                    if (!bus_req_valid && !bus_ack) begin
                        bus_req_valid <= 1'b1;
                    end else if (bus_req_valid && bus_ack) begin
                        bus_req_valid <= 1'b0;
                        byte_cnt      <= '0;
                        state         <= is_write ? C_OPCODE : C_REPLY;
                    end
                end
                C_REPLY: begin
                    if (!tx_req && !tx_ack) begin
                        tx_req <= 1'b1;
                    end else if (tx_req && tx_ack) begin
                        tx_req <= 1'b0;
                        if (byte_cnt == 2'd3) state <= C_OPCODE;
                        byte_cnt <= byte_cnt + 1'b1;
                    end
                end
                default: state <= C_OPCODE;
            endcase
        end
    end

    // frame payload, no reset needed
    always_ff @(posedge clk) begin
        if (state == C_OPCODE && rx_valid) is_write <= (rx_data == board_pkg::OP_WRITE);
        if (state == C_ADDR && rx_valid) addr_q <= rx_data;
        if (state == C_DATA && rx_valid) wdata_q <= {wdata_q[23:0], rx_data};
        if (state == C_BUS && bus_req_valid && bus_ack) begin
            reply_q <= bus_rsp.rdata;
        end else if (state == C_REPLY && tx_req && tx_ack) begin
            reply_q <= {reply_q[23:0], 8'h00};
        end
    end

endmodule

//--- design/uart_transmitter.sv
module uart_transmitter (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_req,
    output logic       tx_ack,
    output logic       tx
);

    localparam int CNT_W = $clog2(board_pkg::CLKS_PER_BIT);

    typedef enum logic [1:0] {
        T_IDLE,
        T_ACK,
        T_SEND
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic [8:0]       shift_q;    // data bits then stop bit

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= T_IDLE;
            tx_ack   <= 1'b0;
            tx       <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                T_IDLE: begin
                    tx <= 1'b1;
                    if (tx_req) begin
                        shift_q <= {1'b1, tx_data};
                        tx_ack  <= 1'b1;
                        state   <= T_ACK;
                    end
                end
                T_ACK: begin
                    if (!tx_req) begin
                        tx_ack   <= 1'b0;
                        tx       <= 1'b0; // start bit
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= T_SEND;
                    end
                end
                T_SEND: begin
                    if (baud_cnt == CNT_W'(board_pkg::CLKS_PER_BIT - 1)) begin
                        baud_cnt <= '0;
                        if (bit_cnt == 4'd9) begin
                            state <= T_IDLE; // stop bit done
                        end else begin
                            tx      <= shift_q[0];
                            shift_q <= {1'b0, shift_q[8:1]};
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= T_IDLE;
            endcase
        end
    end

endmodule

//--- design/uart_receiver.sv
module uart_receiver (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    localparam int CNT_W = $clog2(board_pkg::CLKS_PER_BIT);

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } state_t;

    state_t           state;
    logic             rx_q1;
    logic             rx_s;
    logic [CNT_W-1:0] baud_cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_q1 <= 1'b1;
            rx_s  <= 1'b1;
        end else begin
            rx_q1 <= rx;
            rx_s  <= rx_q1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= R_IDLE;
            baud_cnt <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                R_IDLE: begin
                    baud_cnt <= '0;
                    if (!rx_s) state <= R_START;
                end
                R_START: begin
                    if (baud_cnt == CNT_W'(board_pkg::CLKS_PER_BIT / 2 - 1)) begin
                        baud_cnt <= '0;
                        bit_idx  <= '0;
                        state    <= rx_s ? R_IDLE : R_DATA; // glitch, not a start bit
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                R_DATA: begin
                    if (baud_cnt == CNT_W'(board_pkg::CLKS_PER_BIT - 1)) begin
                        baud_cnt <= '0;
                        if (bit_idx == 3'd7) state <= R_STOP;
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                R_STOP: begin
                    if (baud_cnt == CNT_W'(board_pkg::CLKS_PER_BIT - 1)) begin
                        rx_valid <= rx_s; // framing error drops the byte
                        state    <= R_IDLE;
                    end else begin
                        baud_cnt <= baud_cnt + 1'b1;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge clk) begin
        if (state == R_DATA && baud_cnt == CNT_W'(board_pkg::CLKS_PER_BIT - 1)) begin
            shift_q <= {rx_s, shift_q[7:1]};
        end
        if (state == R_STOP && baud_cnt == CNT_W'(board_pkg::CLKS_PER_BIT - 1)) begin
            rx_data <= shift_q;
        end
    end

endmodule

//--- design/input_debouncer.sv
module input_debouncer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  payload_t raw,
    output payload_t clean
);

    localparam int CNT_W = $clog2(board_pkg::DEBOUNCE_CYCLES + 1);

    payload_t         sync_q1;
    payload_t         sync_q2;
    payload_t         last_q;     // sync value seen on the previous cycle
    logic [CNT_W-1:0] stable_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q1    <= '0;
            sync_q2    <= '0;
            last_q     <= '0;
            stable_cnt <= '0;
            clean      <= '0;
        end else begin
            sync_q1 <= raw;
            sync_q2 <= sync_q1;
            last_q  <= sync_q2;

            if (sync_q2 != last_q) begin
                stable_cnt <= '0; // still bouncing, start over
            end else if (sync_q2 != clean) begin
                if (stable_cnt == CNT_W'(board_pkg::DEBOUNCE_CYCLES - 1)) begin
                    clean      <= sync_q2;
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end else begin
                stable_cnt <= '0;
            end
        end
    end

endmodule

//--- design/board_pkg.sv
package board_pkg;

    // timing, kept short for simulation; a board build raises these
    localparam int CLKS_PER_BIT    = 16;
    localparam int DEBOUNCE_CYCLES = 8;
    localparam int SCAN_CYCLES     = 4;

    // command frame opcodes
    localparam logic [7:0] OP_WRITE = 8'h01;
    localparam logic [7:0] OP_READ  = 8'h02;

    // register map
    localparam logic [7:0] ADDR_LED        = 8'h00;
    localparam logic [7:0] ADDR_SEG_VALUE  = 8'h04;
    localparam logic [7:0] ADDR_SEG_ENABLE = 8'h08;
    localparam logic [7:0] ADDR_SWITCHES   = 8'h0C;
    localparam logic [7:0] ADDR_BUTTONS    = 8'h10;

    typedef logic [15:0] sw_t;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic center;
        logic right;
    } btn_t;

    typedef struct packed {
        logic        write;
        logic [7:0]  addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } bus_rsp_t;

endpackage
